//--- design/mult_array_top.sv
// Vector multiply-accumulate array with issue stage, lanes and collector
module mult_array_top #(
  parameter int NUM_LANES = 4
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       start_i,
  input  mult_ops_pkg::mult_op_e                     op_i,
  input  logic [1:0]                                 signed_i,
  input  logic                                       subword_i,
  input  logic [mult_data_pkg::SHAMT_W-1:0]          imm_i,
  input  logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] op_a_i,
  input  logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] op_b_i,
  input  logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] op_c_i,
  input  logic                                       take_i,
  output logic                                       busy_o,
  output logic                                       result_valid_o,
  output logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] result_o
);

  import mult_ops_pkg::*;
  import mult_data_pkg::*;

  // Held command shared by all lanes
  logic                        cmd_valid;
  mult_op_e                    cmd_op;
  logic [1:0]                  cmd_signed;
  logic                        cmd_subword;
  logic [SHAMT_W-1:0]          cmd_imm;
  logic [NUM_LANES*WORD_W-1:0] cmd_a;
  logic [NUM_LANES*WORD_W-1:0] cmd_b;
  logic [NUM_LANES*WORD_W-1:0] cmd_c;

  // Lane outputs and the retire pulse back
  logic [NUM_LANES*WORD_W-1:0] lane_result;
  logic [NUM_LANES-1:0]        lane_ready;
  logic                        retire;

  mult_issue #(
    .NUM_LANES (NUM_LANES)
  ) i_mult_issue (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .op_i          (op_i),
    .signed_i      (signed_i),
    .subword_i     (subword_i),
    .imm_i         (imm_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .op_c_i        (op_c_i),
    .retire_i      (retire),
    .busy_o        (busy_o),
    .cmd_valid_o   (cmd_valid),
    .cmd_op_o      (cmd_op),
    .cmd_signed_o  (cmd_signed),
    .cmd_subword_o (cmd_subword),
    .cmd_imm_o     (cmd_imm),
    .cmd_a_o       (cmd_a),
    .cmd_b_o       (cmd_b),
    .cmd_c_o       (cmd_c)
  );

  // One lane per operand word
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    mult_lane i_mult_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid_i   (cmd_valid),
      .op_i      (cmd_op),
      .signed_i  (cmd_signed),
      .subword_i (cmd_subword),
      .imm_i     (cmd_imm),
      .op_a_i    (cmd_a[i*WORD_W +: WORD_W]),
      .op_b_i    (cmd_b[i*WORD_W +: WORD_W]),
      .op_c_i    (cmd_c[i*WORD_W +: WORD_W]),
      .retire_i  (retire),
      .result_o  (lane_result[i*WORD_W +: WORD_W]),
      .ready_o   (lane_ready[i])
    );
  end

  mult_collect #(
    .NUM_LANES (NUM_LANES)
  ) i_mult_collect (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid_i    (cmd_valid),
    .lane_ready_i   (lane_ready),
    .lane_result_i  (lane_result),
    .take_i         (take_i),
    .retire_o       (retire),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

//--- design/mult_collect.sv
// Result collector with retire generation and a held output register
module mult_collect #(
  parameter int NUM_LANES = 4
) (
  input  logic                                       clk,
  input  logic                                       rst_n,

  // Command state and per-lane results
  input  logic                                       cmd_valid_i,
  input  logic [NUM_LANES-1:0]                       lane_ready_i,
  input  logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] lane_result_i,

  // Consumer release strobe
  input  logic                                       take_i,

  output logic                                       retire_o,
  output logic                                       result_valid_o,
  output logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] result_o
);

  // Output register can accept a new word this cycle
  logic out_free;

  assign out_free = ~result_valid_o | take_i;

  //////////////////////////////
  // Retire
  //////////////////////////////

  // Every lane has to agree, otherwise the command stays put
  // under back-pressure nothing retires and the lanes keep holding
  assign retire_o = cmd_valid_i & (&lane_ready_i) & out_free;

  //////////////////////////////
  // Output register
  //////////////////////////////

  // Retire with take in the same cycle reloads and keeps valid high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid_o <= 1'b0;
    end else if (retire_o) begin
      result_valid_o <= 1'b1;
    end else if (take_i) begin
      result_valid_o <= 1'b0;
    end
  end

  // All lane words captured together, constant until the next retire
  always_ff @(posedge clk) begin
    if (retire_o) begin
      result_o <= lane_result_i;
    end
  end

endmodule

//--- design/mult_data_pkg.sv
// Operand widths and the byte/halfword view of an operand word
package mult_data_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Operand and result word
  localparam int WORD_W = 32;

  // Subword multiplier and halfword dot inputs
  localparam int HALF_W = 16;

  // Byte dot inputs
  localparam int BYTE_W = 8;

  // Right shift amount of MUL_I and MUL_IR
  localparam int SHAMT_W = 5;

  //////////////////////////////
  // Operand views
  //////////////////////////////

  // Same 32 bits, decoded per operator
  // bytes feed the byte dot unit
  // halves feed the subword multiplier and the halfword dot unit
  // Index 0 is the least significant element in both views
  typedef union packed {
    logic [WORD_W/BYTE_W-1:0][BYTE_W-1:0] bytes;
    logic [WORD_W/HALF_W-1:0][HALF_W-1:0] halves;
  } operand_u;

endpackage

//--- design/mult_issue.sv
// Command issue stage holding one command for all lanes until retire
module mult_issue #(
  parameter int NUM_LANES = 4
) (
  input  logic                                      clk,
  input  logic                                      rst_n,

  // Command from the requester
  input  logic                                      start_i,
  input  mult_ops_pkg::mult_op_e                    op_i,
  input  logic [1:0]                                signed_i,
  input  logic                                      subword_i,
  input  logic [mult_data_pkg::SHAMT_W-1:0]         imm_i,
  input  logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] op_a_i,
  input  logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] op_b_i,
  input  logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] op_c_i,

  // From the collector once every lane is done
  input  logic                                      retire_i,

  output logic                                      busy_o,

  // Held command towards the lanes
  output logic                                      cmd_valid_o,
  output mult_ops_pkg::mult_op_e                    cmd_op_o,
  output logic [1:0]                                cmd_signed_o,
  output logic                                      cmd_subword_o,
  output logic [mult_data_pkg::SHAMT_W-1:0]         cmd_imm_o,
  output logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] cmd_a_o,
  output logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] cmd_b_o,
  output logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] cmd_c_o
);

  // Start is only taken while the stage is empty
  logic accept;

  assign accept = start_i & ~cmd_valid_o;

  //////////////////////////////
  // Valid flag
  //////////////////////////////

  // Set on accept, cleared when the collector retires the command
  // accept and retire never coincide since retire needs a held command
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_valid_o <= 1'b0;
    end else if (accept) begin
      cmd_valid_o <= 1'b1;
    end else if (retire_i) begin
      cmd_valid_o <= 1'b0;
    end
  end

  // Requester sees busy for exactly as long as a command is held
  assign busy_o = cmd_valid_o;

  //////////////////////////////
  // Command register
  //////////////////////////////

  // Sampled once per command, stable for the whole multi-cycle sequence
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_op_o      <= op_i;
      cmd_signed_o  <= signed_i;
      cmd_subword_o <= subword_i;
      cmd_imm_o     <= imm_i;
      // Operand words for every lane, still flattened
      cmd_a_o       <= op_a_i;
      cmd_b_o       <= op_b_i;
      cmd_c_o       <= op_c_i;
    end
  end

endmodule

//--- design/mult_lane.sv
// Multiplier lane with MAC/MSU, subword, upper-half and dot product datapaths
module mult_lane (
  input  logic                              clk,
  input  logic                              rst_n,

  // Command held by the issue stage
  input  logic                              valid_i,
  input  mult_ops_pkg::mult_op_e            op_i,
  input  logic [1:0]                        signed_i,
  input  logic                              subword_i,
  input  logic [mult_data_pkg::SHAMT_W-1:0] imm_i,
  input  logic [mult_data_pkg::WORD_W-1:0]  op_a_i,
  input  logic [mult_data_pkg::WORD_W-1:0]  op_b_i,
  input  logic [mult_data_pkg::WORD_W-1:0]  op_c_i,
  input  logic                              retire_i,

  output logic [mult_data_pkg::WORD_W-1:0]  result_o,
  output logic                              ready_o
);

  import mult_ops_pkg::*;
  import mult_data_pkg::*;

  // Sign-extended halfword and element counts per word
  localparam int SHORT_W = HALF_W + 1;
  localparam int NBYTES  = WORD_W / BYTE_W;
  localparam int NHALVES = WORD_W / HALF_W;

  operand_u a_u;
  operand_u b_u;

  assign a_u = op_a_i;
  assign b_u = op_b_i;

  //////////////////////////////
  // 32-bit MAC / MSU
  //////////////////////////////

  logic [WORD_W-1:0] int_prod;
  logic [WORD_W-1:0] int_result;

  // Low word of the product is the same for signed and unsigned operands
  assign int_prod   = op_a_i * op_b_i;
  assign int_result = (op_i == MUL_MSU32) ? op_c_i - int_prod : op_c_i + int_prod;

  //////////////////////////////
  // Shared 17x17 multiplier
  //////////////////////////////

  mulh_step_e step_q, step_d;

  logic                      carry_q;
  logic [WORD_W-1:0]         acc_q;

  // Per-step controls from the sequencer
  logic                      mh_active;
  logic [SHAMT_W-1:0]        mh_imm;
  logic [1:0]                mh_subword;
  logic [1:0]                mh_signed;
  logic                      mh_arith;
  logic                      mh_save;
  logic                      mh_clear;

  // Muxed controls, sequencer wins while it runs
  logic [SHAMT_W-1:0]        short_imm;
  logic [1:0]                short_subword;
  logic [1:0]                short_signed;
  logic                      short_arith;

  logic [SHORT_W-1:0]        short_op_a;
  logic [SHORT_W-1:0]        short_op_b;
  logic [WORD_W:0]           short_op_c;
  logic [WORD_W-1:0]         round_unit;
  logic [WORD_W-1:0]         short_round;
  logic signed [WORD_W+1:0]  short_mul;
  logic signed [WORD_W+1:0]  short_mac;
  logic                      mac_msb1;
  logic                      mac_msb0;
  logic signed [WORD_W+1:0]  short_shifted;

  assign mh_active     = (step_q != IDLE);
  assign short_imm     = mh_active ? mh_imm     : imm_i;
  assign short_subword = mh_active ? mh_subword : {2{subword_i}};
  assign short_signed  = mh_active ? mh_signed  : signed_i;
  // Single-step shift follows the sign of a
  assign short_arith   = mh_active ? mh_arith   : signed_i[0];

  // Halfword pick through the union, bit 0 for a and bit 1 for b
  assign short_op_a = {short_signed[0] & a_u.halves[short_subword[0]][HALF_W-1],
                       a_u.halves[short_subword[0]]};
  assign short_op_b = {short_signed[1] & b_u.halves[short_subword[1]][HALF_W-1],
                       b_u.halves[short_subword[1]]};

  // Addend is c for single-step work, the running partial sum otherwise
  always_comb begin
    if (!mh_active) begin
      short_op_c = {op_c_i[WORD_W-1], op_c_i};
    end else if (step_q == STEP0) begin
      short_op_c = '0;
    end else begin
      short_op_c = {carry_q, acc_q};
    end
  end

  // Half of 2^imm, only for the rounding variant
  assign round_unit  = {{(WORD_W-1){1'b0}}, 1'b1} << imm_i;
  assign short_round = (op_i == MUL_IR) ? (round_unit >> 1) : '0;

  assign short_mul = $signed(short_op_a) * $signed(short_op_b);
  assign short_mac = $signed(short_op_c) + short_mul + $signed(short_round);

  // Two extra sign bits keep the 34-bit partial sums of the upper-half steps
  assign mac_msb1 = mh_active ? short_mac[WORD_W+1] : short_mac[WORD_W-1];
  assign mac_msb0 = mh_active ? short_mac[WORD_W]   : short_mac[WORD_W-1];

  assign short_shifted = $signed({short_arith & mac_msb1, short_arith & mac_msb0,
                                  short_mac[WORD_W-1:0]}) >>> short_imm;

  //////////////////////////////
  // Upper-half sequencer
  //////////////////////////////

  always_comb begin
    step_d     = step_q;
    mh_imm     = '0;
    mh_subword = 2'b00;
    mh_signed  = 2'b00;
    mh_arith   = 1'b0;
    mh_save    = 1'b0;
    mh_clear   = 1'b0;
    ready_o    = 1'b0;
    case (step_q)
      IDLE: begin
        // Single-step results are ready combinationally
        ready_o = ~(valid_i && (op_i == MUL_H));
        if (valid_i && (op_i == MUL_H)) begin
          step_d = STEP0;
        end
      end
      STEP0: begin
        // aL*bL unsigned, keep only its upper half
        mh_imm = SHAMT_W'(HALF_W);
        step_d = STEP1;
      end
      STEP1: begin
        // aL*bH, signed when b is, 33-bit sum saved with its carry
        mh_signed  = {signed_i[1], 1'b0};
        mh_subword = 2'b10;
        mh_arith   = 1'b1;
        mh_save    = 1'b1;
        step_d     = STEP2;
      end
      STEP2: begin
        mh_signed  = {1'b0, signed_i[0]};
        mh_subword = 2'b01;
        mh_imm     = SHAMT_W'(HALF_W);
        mh_arith   = 1'b1;
        mh_save    = 1'b1;
        // Carry bits are shifted back in, nothing left to keep
        mh_clear   = 1'b1;
        step_d     = FINISH;
      end
      FINISH: begin
        // aH*bH plus partial sum gives the high word
        mh_signed  = signed_i;
        mh_subword = 2'b11;
        ready_o    = 1'b1;
        if (retire_i) begin
          step_d = IDLE;
        end
      end
      default: step_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q  <= IDLE;
      carry_q <= 1'b0;
    end else begin
      step_q <= step_d;
      if (mh_save) begin
        carry_q <= ~mh_clear & short_mac[WORD_W];
      end else if (retire_i) begin
        carry_q <= 1'b0;
      end
    end
  end

  // Partial sum from each of the three steps
  always_ff @(posedge clk) begin
    if ((step_q == STEP0) || (step_q == STEP1) || (step_q == STEP2)) begin
      acc_q <= short_shifted[WORD_W-1:0];
    end
  end

  //////////////////////////////
  // Dot product units
  //////////////////////////////

  logic signed [WORD_W-1:0] dot8_acc;
  logic signed [WORD_W-1:0] dot16_acc;

  // Products sign-extended to the word before summing
  always_comb begin
    dot8_acc = $signed(op_c_i);
    for (int i = 0; i < NBYTES; i++) begin
      dot8_acc = dot8_acc +
                 $signed({signed_i[0] & a_u.bytes[i][BYTE_W-1], a_u.bytes[i]}) *
                 $signed({signed_i[1] & b_u.bytes[i][BYTE_W-1], b_u.bytes[i]});
    end
  end

  always_comb begin
    dot16_acc = $signed(op_c_i);
    for (int i = 0; i < NHALVES; i++) begin
      dot16_acc = dot16_acc +
                  $signed({signed_i[0] & a_u.halves[i][HALF_W-1], a_u.halves[i]}) *
                  $signed({signed_i[1] & b_u.halves[i][HALF_W-1], b_u.halves[i]});
    end
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    unique case (op_i)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR, MUL_H: result_o = short_shifted[WORD_W-1:0];
      MUL_DOT8:             result_o = dot8_acc;
      MUL_DOT16:            result_o = dot16_acc;
      default:              result_o = '0;
    endcase
  end

endmodule

//--- design/mult_ops_pkg.sv
// Operator encoding and upper-half step states for the multiplier array
package mult_ops_pkg;

  //////////////////////////////
  // Lane operators
  //////////////////////////////

  // One operator per command, applied identically on every lane
  typedef enum logic [2:0] {
    // c + a*b, low word
    MUL_MAC32 = 3'b000,
    // c - a*b, low word
    MUL_MSU32 = 3'b001,
    // Halfword product plus c, shifted right by imm
    MUL_I     = 3'b010,
    // Same as MUL_I with half an LSB of the shift added first
    MUL_IR    = 3'b011,
    // Sum of four byte products plus c
    MUL_DOT8  = 3'b100,
    // Sum of two halfword products plus c
    MUL_DOT16 = 3'b101,
    // Upper word of the full 64-bit product, four cycles
    MUL_H     = 3'b110
  } mult_op_e;

  //////////////////////////////
  // Upper-half sequencer
  //////////////////////////////

  // IDLE also serves every single-step operator
  // STEP0 to STEP2 build partial sums in the lane accumulator
  // FINISH adds the high product and holds until retire
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    STEP0  = 3'd1,
    STEP1  = 3'd2,
    STEP2  = 3'd3,
    FINISH = 3'd4
  } mulh_step_e;

endpackage

//--- list.f
design/mult_ops_pkg.sv
design/mult_data_pkg.sv
design/mult_issue.sv
design/mult_lane.sv
design/mult_collect.sv
design/mult_array_top.sv
tb/mult_array_properties.sv
tb/mult_array_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the multiplier array testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f \
  --top-module mult_array_tb \
  -o mult_array_sim

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/mult_array_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished, see sim.log"

//--- tb/mult_array_properties.sv
// Bound checker with a per-lane reference model and flow-control assertions
module mult_array_properties #(
  parameter int NUM_LANES = 4
) (
  input logic                                       clk,
  input logic                                       rst_n,
  input logic                                       start_i,
  input mult_ops_pkg::mult_op_e                     op_i,
  input logic [1:0]                                 signed_i,
  input logic                                       subword_i,
  input logic [mult_data_pkg::SHAMT_W-1:0]          imm_i,
  input logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] op_a_i,
  input logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] op_b_i,
  input logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] op_c_i,
  input logic                                       take_i,
  input logic                                       busy_i,
  input logic                                       retire_i,
  input logic                                       result_valid_i,
  input logic [NUM_LANES*mult_data_pkg::WORD_W-1:0] result_i
);

  import mult_ops_pkg::*;
  import mult_data_pkg::*;

  int fail_count = 0;

  logic                        accept;
  logic                        out_free;
  logic                        acc_single_q;
  logic [2:0]                  mh_age;
  logic [NUM_LANES*WORD_W-1:0] exp_cmd;
  logic [NUM_LANES*WORD_W-1:0] exp_out;

  // Expected word of one lane, straight from the operator definitions
  function automatic logic [WORD_W-1:0] model_word(mult_op_e op, logic [1:0] sgn, logic sub,
                                                   logic [SHAMT_W-1:0] imm, logic [WORD_W-1:0] a,
                                                   logic [WORD_W-1:0] b, logic [WORD_W-1:0] c);
    operand_u           ua;
    operand_u           ub;
    longint             sa;
    longint             sb;
    longint             sum;
    logic [WORD_W-1:0]  lo;
    logic signed [65:0] wa;
    logic signed [65:0] wb;
    logic signed [65:0] wp;
    logic [WORD_W-1:0]  res;
    ua  = a;
    ub  = b;
    sum = longint'(c);
    res = '0;
    case (op)
      MUL_MAC32: res = c + a * b;
      MUL_MSU32: res = c - a * b;
      MUL_I, MUL_IR: begin
        sa  = sgn[0] ? longint'($signed(ua.halves[sub])) : longint'(ua.halves[sub]);
        sb  = sgn[1] ? longint'($signed(ub.halves[sub])) : longint'(ub.halves[sub]);
        sum = sum + sa * sb;
        // Half of 2^imm, nothing to add for a zero shift
        if ((op == MUL_IR) && (imm != 0)) begin
          sum = sum + (longint'(1) << (imm - 5'd1));
        end
        lo  = sum[31:0];
        res = sgn[0] ? 32'($signed(lo) >>> imm) : (lo >> imm);
      end
      MUL_H: begin
        wa  = sgn[0] ? {{34{a[31]}}, a} : {34'b0, a};
        wb  = sgn[1] ? {{34{b[31]}}, b} : {34'b0, b};
        wp  = wa * wb;
        res = wp[63:32];
      end
      MUL_DOT8: begin
        for (int i = 0; i < 4; i++) begin
          sa  = sgn[0] ? longint'($signed(ua.bytes[i])) : longint'(ua.bytes[i]);
          sb  = sgn[1] ? longint'($signed(ub.bytes[i])) : longint'(ub.bytes[i]);
          sum = sum + sa * sb;
        end
        res = sum[31:0];
      end
      MUL_DOT16: begin
        for (int i = 0; i < 2; i++) begin
          sa  = sgn[0] ? longint'($signed(ua.halves[i])) : longint'(ua.halves[i]);
          sb  = sgn[1] ? longint'($signed(ub.halves[i])) : longint'(ub.halves[i]);
          sum = sum + sa * sb;
        end
        res = sum[31:0];
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  //////////////////////////////
  // Command tracking
  //////////////////////////////

  assign accept   = start_i & ~busy_i;
  assign out_free = ~result_valid_i | take_i;

  // Expected words follow the held command into the output register
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        exp_cmd[i*WORD_W +: WORD_W] <= model_word(op_i, signed_i, subword_i, imm_i,
                                                  op_a_i[i*WORD_W +: WORD_W],
                                                  op_b_i[i*WORD_W +: WORD_W],
                                                  op_c_i[i*WORD_W +: WORD_W]);
      end
    end
    if (retire_i) begin
      exp_out <= exp_cmd;
    end
  end

  // Cycles since an upper-half start, 1 to 5
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_single_q <= 1'b0;
      mh_age       <= '0;
    end else begin
      acc_single_q <= accept & (op_i != MUL_H);
      if (accept && (op_i == MUL_H)) begin
        mh_age <= 3'd1;
      end else if (mh_age == 3'd5) begin
        mh_age <= '0;
      end else if (mh_age != 3'd0) begin
        mh_age <= mh_age + 3'd1;
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  a_result: assert property (@(posedge clk) disable iff (!rst_n)
    retire_i |=> result_valid_i && (result_i == exp_out))
    else begin
      fail_count++;
      $error("ERROR t=%0t result_o exp %h got %h", $time, $sampled(exp_out),
             $sampled(result_i));
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid_i && !take_i |=> result_valid_i && $stable(result_i))
    else begin
      fail_count++;
      $error("Held result changed or dropped while take_i was low");
    end

  // Busy from the edge after an accepted start up to the edge after retire
  a_busy_set: assert property (@(posedge clk) disable iff (!rst_n)
    accept || (busy_i && !retire_i) |=> busy_i)
    else begin
      fail_count++;
      $error("busy_o low while a command was still held");
    end

  a_busy_clear: assert property (@(posedge clk) disable iff (!rst_n)
    retire_i || (!busy_i && !accept) |=> !busy_i)
    else begin
      fail_count++;
      $error("busy_o high with no command held");
    end

  a_single_latency: assert property (@(posedge clk) disable iff (!rst_n)
    acc_single_q && out_free |-> retire_i)
    else begin
      fail_count++;
      $error("Single-step command did not complete two edges after start");
    end

  a_mulh_steps: assert property (@(posedge clk) disable iff (!rst_n)
    (mh_age != 3'd0) && (mh_age < 3'd5) |-> !retire_i)
    else begin
      fail_count++;
      $error("Upper-half command retired before its four steps were done");
    end

  a_mulh_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (mh_age == 3'd5) && out_free |-> retire_i)
    else begin
      fail_count++;
      $error("Upper-half command did not complete six edges after start");
    end

endmodule

bind mult_array_top mult_array_properties #(
  .NUM_LANES (NUM_LANES)
) i_mult_array_properties (
  .clk            (clk),
  .rst_n          (rst_n),
  .start_i        (start_i),
  .op_i           (op_i),
  .signed_i       (signed_i),
  .subword_i      (subword_i),
  .imm_i          (imm_i),
  .op_a_i         (op_a_i),
  .op_b_i         (op_b_i),
  .op_c_i         (op_c_i),
  .take_i         (take_i),
  .busy_i         (busy_o),
  .retire_i       (retire),
  .result_valid_i (result_valid_o),
  .result_i       (result_o)
);

//--- tb/mult_array_tb.sv
// Testbench top with clock, reset, directed and random commands, result count and watchdog
module mult_array_tb;

  import mult_ops_pkg::*;
  import mult_data_pkg::*;

  localparam int NUM_LANES    = 4;
  localparam int NUM_DIRECTED = 13;
  localparam int NUM_RANDOM   = 300;
  localparam int CLK_PERIOD   = 4;
  // Twenty cycles per command covers the upper-half sequence under back-pressure
  localparam int WATCHDOG_TIME = ((NUM_DIRECTED + NUM_RANDOM) * 20 + 20) * CLK_PERIOD;

  typedef logic [NUM_LANES*WORD_W-1:0] lanes_t;

  logic               clk;
  logic               rst_n;
  logic               start_i;
  mult_op_e           op_i;
  logic [1:0]         signed_i;
  logic               subword_i;
  logic [SHAMT_W-1:0] imm_i;
  lanes_t             op_a_i;
  lanes_t             op_b_i;
  lanes_t             op_c_i;
  logic               take_i;
  logic               busy_o;
  logic               result_valid_o;
  lanes_t             result_o;

  int issued       = 0;
  int received     = 0;
  int count_errors = 0;
  int checker_fails;

  mult_array_top #(
    .NUM_LANES (NUM_LANES)
  ) i_mult_array_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .op_i           (op_i),
    .signed_i       (signed_i),
    .subword_i      (subword_i),
    .imm_i          (imm_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .op_c_i         (op_c_i),
    .take_i         (take_i),
    .busy_o         (busy_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  //////////////////////////////
  // Clock, take and watchdog
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Consumer withholds take about one cycle in three
  initial begin
    take_i = 1'b0;
    forever begin
      @(negedge clk);
      take_i = ($urandom_range(0, 2) != 0);
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired after %0d time units with %0d of %0d results received",
             WATCHDOG_TIME, received, issued);
    $display("Verification failed");
    $finish;
  end

  // A result leaves the array on every edge where it is valid and taken
  always @(posedge clk) begin
    if (rst_n && result_valid_o && take_i) begin
      received <= received + 1;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic lanes_t random_lanes();
    lanes_t v;
    for (int i = 0; i < NUM_LANES; i++) begin
      v[i*WORD_W +: WORD_W] = $urandom();
    end
    return v;
  endfunction

  // Most negative, all ones and most positive words, rotated per operand
  function automatic lanes_t corner_lanes(int rot);
    lanes_t v;
    for (int i = 0; i < NUM_LANES; i++) begin
      case ((i + rot) % 4)
        0:       v[i*WORD_W +: WORD_W] = 32'h8000_0000;
        1:       v[i*WORD_W +: WORD_W] = 32'hFFFF_FFFF;
        2:       v[i*WORD_W +: WORD_W] = 32'h7FFF_FFFF;
        default: v[i*WORD_W +: WORD_W] = $urandom();
      endcase
    end
    return v;
  endfunction

  // Called at a falling edge, returns one falling edge after the start pulse
  task automatic send_cmd(input mult_op_e op, input logic [1:0] sgn, input logic sub,
                          input logic [SHAMT_W-1:0] imm, input lanes_t a, input lanes_t b,
                          input lanes_t c);
    while (busy_o) begin
      // Stray start with junk operands, the issue stage must drop it
      start_i = ($urandom_range(0, 3) == 0);
      op_i    = mult_op_e'(3'($urandom_range(0, 6)));
      op_a_i  = random_lanes();
      @(negedge clk);
    end
    start_i   = 1'b1;
    op_i      = op;
    signed_i  = sgn;
    subword_i = sub;
    imm_i     = imm;
    op_a_i    = a;
    op_b_i    = b;
    op_c_i    = c;
    @(negedge clk);
    start_i = 1'b0;
    issued++;
  endtask

  task automatic send_random();
    mult_op_e   op;
    logic [1:0] sgn;
    op  = mult_op_e'(3'($urandom_range(0, 6)));
    sgn = 2'($urandom_range(0, 3));
    // Upper-half sign modes are 11, 01 and 00
    if ((op == MUL_H) && (sgn == 2'b10)) begin
      sgn = 2'b11;
    end
    send_cmd(op, sgn, 1'($urandom_range(0, 1)), SHAMT_W'($urandom_range(0, 31)),
             random_lanes(), random_lanes(), random_lanes());
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(5829));
    rst_n     = 1'b0;
    start_i   = 1'b0;
    op_i      = MUL_MAC32;
    signed_i  = 2'b00;
    subword_i = 1'b0;
    imm_i     = '0;
    op_a_i    = '0;
    op_b_i    = '0;
    op_c_i    = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Upper half with extreme operands in all three sign modes
    for (int k = 0; k < 3; k++) begin
      send_cmd(MUL_H, (k == 0) ? 2'b11 : ((k == 1) ? 2'b01 : 2'b00), 1'b0, '0,
               corner_lanes(0), corner_lanes(k + 1), random_lanes());
    end
    send_cmd(MUL_MAC32, 2'b11, 1'b0, '0, corner_lanes(0), random_lanes(), random_lanes());
    send_cmd(MUL_MSU32, 2'b00, 1'b0, '0, random_lanes(), corner_lanes(2), random_lanes());
    for (int k = 0; k < 2; k++) begin
      send_cmd(MUL_I, 2'(k * 3), k[0], SHAMT_W'($urandom_range(0, 31)),
               corner_lanes(k), random_lanes(), random_lanes());
      send_cmd(MUL_IR, 2'(k * 3), ~k[0], SHAMT_W'($urandom_range(1, 31)),
               random_lanes(), corner_lanes(k), random_lanes());
      send_cmd(MUL_DOT8, {k[0], ~k[0]}, 1'b0, '0, corner_lanes(k), random_lanes(),
               random_lanes());
      send_cmd(MUL_DOT16, {~k[0], k[0]}, 1'b0, '0, random_lanes(), corner_lanes(k),
               random_lanes());
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      send_random();
    end

    // Drain the array until the last result is taken
    while (busy_o || result_valid_o) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);

    if (received != issued) begin
      count_errors++;
      $display("ERROR t=%0t results_received exp %0d got %0d", $time, issued, received);
    end
    checker_fails = i_mult_array_top.i_mult_array_properties.fail_count;
    $display("Commands issued %0d, results received %0d, checker failures %0d, count errors %0d",
             issued, received, checker_fails, count_errors);
    if ((checker_fails == 0) && (count_errors == 0)) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
